/* common/csc_pkg.sv */
/*
  CSC upsampler shared definitions
  Memory map, image geometry, filter and colour coefficients,
  vector types, bus structs and the fetch FSM states
*/

package csc_pkg;

	typedef logic [17:0] sram_addr_t;
	typedef logic [15:0] sram_word_t;
	typedef logic [7:0] pixel_t;
	typedef logic signed [31:0] product_t;
	typedef logic [15:0] pair_count_t;

	typedef struct packed {
		sram_addr_t addr;
		sram_word_t wdata;
		logic we;            // High for a write
	} sram_req_t;

	typedef struct packed {
		pixel_t y_even;
		pixel_t y_odd;
		pixel_t u_even;
		pixel_t u_odd;
		pixel_t v_even;
		pixel_t v_odd;
	} yuv_pair_t;

	typedef struct packed {
		pixel_t r_even;
		pixel_t g_even;
		pixel_t b_even;
		pixel_t r_odd;
		pixel_t g_odd;
		pixel_t b_odd;
	} rgb_pair_t;

	typedef enum logic [1:0] {F_IDLE, F_ISSUE, F_WAIT, F_EMIT} fetch_state_t;

	localparam int IMG_WIDTH = 320;
	localparam int IMG_HEIGHT = 240;
	localparam int PAIRS_PER_ROW = 160;
	localparam int CHROMA_PER_ROW = 160;

	// Word addresses in the SRAM
	localparam sram_addr_t Y_BASE = 18'd0;
	localparam sram_addr_t U_BASE = 18'd38400;
	localparam sram_addr_t V_BASE = 18'd57600;
	localparam sram_addr_t RGB_BASE = 18'd146944;

	localparam int SRAM_READ_LATENCY = 2;

	// Six-tap chroma interpolation
	localparam product_t FILTER_TAP_OUTER = 21;
	localparam product_t FILTER_TAP_MID = 52;
	localparam product_t FILTER_TAP_INNER = 159;
	localparam product_t FILTER_ROUND = 128;
	localparam int FILTER_SHIFT = 8;

	localparam product_t Y_BIAS = 16;
	localparam product_t CHROMA_BIAS = 128;

	// Colour matrix in 16-bit fraction
	localparam product_t COEF_Y = 76284;
	localparam product_t COEF_RV = 104595;
	localparam product_t COEF_GU = 25624;
	localparam product_t COEF_GV = 53281;
	localparam product_t COEF_BU = 132251;
	localparam int COEF_SHIFT = 16;

	localparam int STORE_DEPTH = 8;    // Pairs
	localparam int STORE_SLACK = 4;    // Free slots kept for the pipeline

	// Saturate a scaled result to one sample
	function automatic pixel_t clip_pixel(input product_t value);
		if (value < 0)
			return 8'h00;
		if (value > 255)
			return 8'hff;
		return value[7:0];
	endfunction

endpackage

/* hdl/sram_arbiter.sv */
/*
  SRAM port arbiter
  Store unit wins over fetch, the winning command is registered onto
  the pins and granted reads are tracked until their data returns
*/

`timescale 1ns/100ps

module sram_arbiter import csc_pkg::*; (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic fetch_req,
	input sram_req_t fetch_cmd,
	output logic fetch_grant,
	output logic read_valid,
	output sram_word_t read_data,
	input logic store_req,
	input sram_req_t store_cmd,
	output logic store_grant,
	output sram_addr_t sram_addr,
	output sram_word_t sram_wdata,
	output logic sram_we_n,
	input sram_word_t sram_rdata
);

	// Bit 0 marks a fetch read on the pins, the top bit its returning word
	logic [SRAM_READ_LATENCY:0] rd_pipe;

	assign store_grant = store_req;
	assign fetch_grant = fetch_req && !store_req;

	assign read_valid = rd_pipe[SRAM_READ_LATENCY];
	assign read_data = sram_rdata;    // Valid two cycles after the address is on the pins

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			sram_we_n <= 1'b1;
			rd_pipe <= '0;
		end else begin
			sram_we_n <= !(store_grant && store_cmd.we);
			rd_pipe <= {rd_pipe[SRAM_READ_LATENCY-1:0], fetch_grant};
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (store_grant) begin
			sram_addr <= store_cmd.addr;
			sram_wdata <= store_cmd.wdata;
		end else begin
			sram_addr <= fetch_cmd.addr;    // Idle cycles read harmlessly
			sram_wdata <= fetch_cmd.wdata;
		end
	end

endmodule

/* upsample/yuv_fetch.sv */
/*
  Frame fetch controller
  Walks the frame row by row, reads Y, U and V words in order and
  streams chroma samples and pixel pairs to the interpolator
*/

`timescale 1ns/100ps

module yuv_fetch import csc_pkg::*; (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic start,
	output logic busy,
	output logic fetch_req,
	output sram_req_t fetch_cmd,
	input logic fetch_grant,
	input logic read_valid,
	input sram_word_t read_data,
	input logic store_room,
	output logic row_start,
	output logic chroma_shift,
	output pixel_t u_in,
	output pixel_t v_in,
	output logic pair_valid,
	output pixel_t y_even,
	output pixel_t y_odd,
	output logic last_pair
);

	fetch_state_t state;
	logic [7:0] step;          // Chroma sample step within the row
	pair_count_t pair_idx;     // Also the Y word offset
	sram_addr_t c_ptr;         // Chroma word offset
	logic [1:0] icnt, rcnt, rneed;
	logic need_c, need_y;
	sram_word_t u_word, v_word, y_word;
	pixel_t u_lo, v_lo;

	// Step s feeds sample s, clamped at the row end; pairs start at step 4
	assign need_c = !step[0] && (step < CHROMA_PER_ROW);
	assign need_y = step >= 8'd4;
	assign rneed = {need_c, need_y};    // U and V words, then Y

	always_comb begin
		fetch_cmd = '0;
		if (need_c && icnt == 2'd0)
			fetch_cmd.addr = U_BASE + c_ptr;
		else if (need_c && icnt == 2'd1)
			fetch_cmd.addr = V_BASE + c_ptr;
		else
			fetch_cmd.addr = Y_BASE + sram_addr_t'(pair_idx);
	end

	assign fetch_req = (state == F_ISSUE) && (rneed != 2'd0) && store_room;
	assign busy = state != F_IDLE;

	assign row_start = (state == F_EMIT) && (step == 8'd0);
	assign chroma_shift = (state == F_EMIT) && (step != 8'd0);
	assign pair_valid = (state == F_EMIT) && need_y;
	assign u_in = need_c ? u_word[15:8] : u_lo;    // Low byte serves the next step
	assign v_in = need_c ? v_word[15:8] : v_lo;
	assign y_even = y_word[15:8];
	assign y_odd = y_word[7:0];
	assign last_pair = pair_valid && (pair_idx == pair_count_t'(PAIRS_PER_ROW * IMG_HEIGHT - 1));

	// Returned words arrive in issue order
	always_ff @(posedge CLOCK_50_I) begin
		if (read_valid) begin
			if (need_c && rcnt == 2'd0)
				u_word <= read_data;
			else if (need_c && rcnt == 2'd1)
				v_word <= read_data;
			else
				y_word <= read_data;
		end
		if (state == F_EMIT && need_c) begin
			u_lo <= u_word[7:0];
			v_lo <= v_word[7:0];
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			state <= F_IDLE;
			step <= '0;
			pair_idx <= '0;
			c_ptr <= '0;
			icnt <= '0;
			rcnt <= '0;
		end else begin
			if (read_valid)
				rcnt <= rcnt + 1'b1;
			case (state)
			F_IDLE: begin
				if (start) begin
					step <= '0;
					pair_idx <= '0;
					c_ptr <= '0;
					icnt <= '0;
					rcnt <= '0;
					state <= F_ISSUE;
				end
			end
			F_ISSUE: begin
				if (rneed == 2'd0) begin
					state <= F_EMIT;    // Priming step with data already held
				end else if (fetch_grant) begin
					icnt <= icnt + 1'b1;
					if (icnt == rneed - 2'd1)
						state <= F_WAIT;
				end
			end
			F_WAIT: begin
				if (read_valid && rcnt == rneed - 2'd1)
					state <= F_EMIT;
			end
			F_EMIT: begin
				icnt <= '0;
				rcnt <= '0;
				if (need_c)
					c_ptr <= c_ptr + 1'b1;
				if (need_y)
					pair_idx <= pair_idx + 1'b1;
				step <= (step == PAIRS_PER_ROW + 3) ? 8'd0 : step + 1'b1;
				state <= last_pair ? F_IDLE : F_ISSUE;
			end
			default: state <= F_IDLE;
			endcase
		end
	end

endmodule

/* upsample/chroma_interpolator.sv */
/*
  Chroma interpolator
  Six-sample U and V windows, even chroma taken as is and odd
  chroma rebuilt with the 21/52/159 filter
*/

`timescale 1ns/100ps

module chroma_interpolator import csc_pkg::*; (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic row_start,
	input logic chroma_shift,
	input pixel_t u_in,
	input pixel_t v_in,
	input logic pair_valid,
	input pixel_t y_even,
	input pixel_t y_odd,
	input logic last_pair,
	output logic yuv_valid,
	output yuv_pair_t yuv,
	output logic yuv_last
);

	// Index 0 is the oldest sample, 2 and 3 straddle the odd pixel
	pixel_t [5:0] u_win;
	pixel_t [5:0] v_win;

	function automatic pixel_t odd_sample(input pixel_t [5:0] w);
		product_t acc;
		acc = FILTER_TAP_OUTER * (product_t'(w[0]) + product_t'(w[5]))
			- FILTER_TAP_MID * (product_t'(w[1]) + product_t'(w[4]))
			+ FILTER_TAP_INNER * (product_t'(w[2]) + product_t'(w[3]))
			+ FILTER_ROUND;
		return clip_pixel(acc >>> FILTER_SHIFT);
	endfunction

	always_ff @(posedge CLOCK_50_I) begin
		if (row_start) begin
			u_win <= {6{u_in}};    // Left edge replicated
			v_win <= {6{v_in}};
		end else if (chroma_shift) begin
			u_win <= {u_in, u_win[5:1]};
			v_win <= {v_in, v_win[5:1]};
		end
	end

	// Pair uses the window as it stands before this cycle's shift
	always_ff @(posedge CLOCK_50_I) begin
		if (pair_valid) begin
			yuv.y_even <= y_even;
			yuv.y_odd <= y_odd;
			yuv.u_even <= u_win[2];
			yuv.u_odd <= odd_sample(u_win);
			yuv.v_even <= v_win[2];
			yuv.v_odd <= odd_sample(v_win);
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			yuv_valid <= 1'b0;
			yuv_last <= 1'b0;
		end else begin
			yuv_valid <= pair_valid;
			yuv_last <= pair_valid && last_pair;
		end
	end

endmodule

/* hdl/csc_matrix.sv */
/*
  YUV to RGB matrix
  Three stages: bias removal, coefficient products and sums,
  then scaling and saturation to eight bits
*/

`timescale 1ns/100ps

module csc_matrix import csc_pkg::*; (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic yuv_valid,
	input yuv_pair_t yuv,
	input logic yuv_last,
	output logic rgb_valid,
	output rgb_pair_t rgb,
	output logic rgb_last
);

	// Index 0 even pixel, 1 odd pixel
	product_t y_s [2];
	product_t u_s [2];
	product_t v_s [2];
	product_t r_s [2];
	product_t g_s [2];
	product_t b_s [2];
	logic [2:0] valid_pipe;
	logic [2:0] last_pipe;

	always_ff @(posedge CLOCK_50_I) begin
		y_s[0] <= product_t'(yuv.y_even) - Y_BIAS;
		y_s[1] <= product_t'(yuv.y_odd) - Y_BIAS;
		u_s[0] <= product_t'(yuv.u_even) - CHROMA_BIAS;
		u_s[1] <= product_t'(yuv.u_odd) - CHROMA_BIAS;
		v_s[0] <= product_t'(yuv.v_even) - CHROMA_BIAS;
		v_s[1] <= product_t'(yuv.v_odd) - CHROMA_BIAS;

		for (int i = 0; i < 2; i++) begin
			r_s[i] <= COEF_Y * y_s[i] + COEF_RV * v_s[i];
			g_s[i] <= COEF_Y * y_s[i] - COEF_GU * u_s[i] - COEF_GV * v_s[i];
			b_s[i] <= COEF_Y * y_s[i] + COEF_BU * u_s[i];
		end

		rgb.r_even <= clip_pixel(r_s[0] >>> COEF_SHIFT);
		rgb.g_even <= clip_pixel(g_s[0] >>> COEF_SHIFT);
		rgb.b_even <= clip_pixel(b_s[0] >>> COEF_SHIFT);
		rgb.r_odd <= clip_pixel(r_s[1] >>> COEF_SHIFT);
		rgb.g_odd <= clip_pixel(g_s[1] >>> COEF_SHIFT);
		rgb.b_odd <= clip_pixel(b_s[1] >>> COEF_SHIFT);
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			valid_pipe <= '0;
			last_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[1:0], yuv_valid};
			last_pipe <= {last_pipe[1:0], yuv_last};
		end
	end

	assign rgb_valid = valid_pipe[2];
	assign rgb_last = last_pipe[2];

endmodule

/* hdl/rgb_store.sv */
/*
  RGB store unit
  Buffers converted pairs, writes each as three packed words
  and flags frame completion after the last one lands
*/

`timescale 1ns/100ps

module rgb_store import csc_pkg::*; (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic rgb_valid,
	input rgb_pair_t rgb,
	input logic rgb_last,
	output logic store_req,
	output sram_req_t store_cmd,
	input logic store_grant,
	output logic store_room,
	output logic done
);

	rgb_pair_t fifo_mem [STORE_DEPTH];
	logic [STORE_DEPTH-1:0] last_mem;
	logic [$clog2(STORE_DEPTH)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(STORE_DEPTH):0] count;
	logic [1:0] word_idx;      // Word of the head pair being written
	pair_count_t pair_cnt;
	rgb_pair_t head;
	logic pop;
	logic done_pre;

	assign head = fifo_mem[rd_ptr];
	assign pop = store_grant && (word_idx == 2'd2);
	assign store_req = count != '0;
	assign store_room = (STORE_DEPTH - count) >= STORE_SLACK;

	always_comb begin
		store_cmd.we = 1'b1;
		store_cmd.addr = RGB_BASE + sram_addr_t'({pair_cnt, 1'b0}) + sram_addr_t'(pair_cnt)
			+ sram_addr_t'(word_idx);    // Three words per pair
		case (word_idx)
		2'd0: store_cmd.wdata = {head.r_even, head.g_even};
		2'd1: store_cmd.wdata = {head.b_even, head.r_odd};
		default: store_cmd.wdata = {head.g_odd, head.b_odd};
		endcase
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (rgb_valid) begin
			fifo_mem[wr_ptr] <= rgb;
			last_mem[wr_ptr] <= rgb_last;
		end
	end

	always_ff @(posedge CLOCK_50_I or negedge resetn) begin
		if (!resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			word_idx <= '0;
			pair_cnt <= '0;
			done_pre <= 1'b0;
			done <= 1'b0;
		end else begin
			done_pre <= pop && last_mem[rd_ptr];
			done <= done_pre;    // Write has reached the memory by now
			if (rgb_valid)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop) begin
				word_idx <= '0;
				rd_ptr <= rd_ptr + 1'b1;
				pair_cnt <= last_mem[rd_ptr] ? '0 : pair_cnt + 1'b1;
			end else if (store_grant) begin
				word_idx <= word_idx + 1'b1;
			end
			case ({rgb_valid, pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: count <= count;
			endcase
		end
	end

endmodule

/* hdl/csc_top.sv */
/*
  CSC upsampler top level
  Fetch, interpolation, colour matrix and store units sharing one SRAM port
*/

`timescale 1ns/100ps

module csc_top import csc_pkg::*; (
	input logic CLOCK_50_I,
	input logic resetn,
	input logic start,
	output logic busy,
	output logic done,
	output sram_addr_t sram_addr,
	output sram_word_t sram_wdata,
	output logic sram_we_n,
	input sram_word_t sram_rdata
);

	logic fetch_req, fetch_grant, read_valid;
	sram_req_t fetch_cmd;
	sram_word_t read_data;
	logic store_req, store_grant, store_room;
	sram_req_t store_cmd;

	logic row_start, chroma_shift, pair_valid, last_pair;
	pixel_t u_in, v_in, y_even, y_odd;

	logic yuv_valid, yuv_last;
	yuv_pair_t yuv;
	logic rgb_valid, rgb_last;
	rgb_pair_t rgb;

	sram_arbiter arbiter_unit (
		.CLOCK_50_I, .resetn,
		.fetch_req, .fetch_cmd, .fetch_grant, .read_valid, .read_data,
		.store_req, .store_cmd, .store_grant,
		.sram_addr, .sram_wdata, .sram_we_n, .sram_rdata
	);

	yuv_fetch fetch_unit (
		.CLOCK_50_I, .resetn, .start, .busy,
		.fetch_req, .fetch_cmd, .fetch_grant, .read_valid, .read_data,
		.store_room,
		.row_start, .chroma_shift, .u_in, .v_in,
		.pair_valid, .y_even, .y_odd, .last_pair
	);

	chroma_interpolator interp_unit (
		.CLOCK_50_I, .resetn,
		.row_start, .chroma_shift, .u_in, .v_in,
		.pair_valid, .y_even, .y_odd, .last_pair,
		.yuv_valid, .yuv, .yuv_last
	);

	csc_matrix matrix_unit (
		.CLOCK_50_I, .resetn,
		.yuv_valid, .yuv, .yuv_last,
		.rgb_valid, .rgb, .rgb_last
	);

	rgb_store store_unit (
		.CLOCK_50_I, .resetn,
		.rgb_valid, .rgb, .rgb_last,
		.store_req, .store_cmd, .store_grant, .store_room, .done
	);

endmodule

/* test/sram_model.sv */
/*
  Behavioural SRAM for the testbench
  2^18 by 16 words with a two-cycle read latency, a load port for
  test images and counters for written and stray words
*/

`timescale 1ns/100ps

module sram_model import csc_pkg::*; (
	input logic CLOCK_50_I,
	input sram_addr_t sram_addr,
	input sram_word_t sram_wdata,
	input logic sram_we_n,
	output sram_word_t sram_rdata,
	input logic load_en,
	input sram_addr_t load_addr,
	input sram_word_t load_data,
	input logic clear_counts,
	output int write_count,
	output int stray_count
);

	sram_word_t mem [2**18];
	sram_word_t rd_stage;    // First cycle of the read

	always_ff @(posedge CLOCK_50_I) begin
		rd_stage <= mem[sram_addr];
		sram_rdata <= rd_stage;
		if (load_en)
			mem[load_addr] <= load_data;    // Test image load
		else if (!sram_we_n)
			mem[sram_addr] <= sram_wdata;
	end

	// Writes outside the RGB area count as stray
	always_ff @(posedge CLOCK_50_I) begin
		if (clear_counts) begin
			write_count <= 0;
			stray_count <= 0;
		end else if (!sram_we_n && !load_en) begin
			write_count <= write_count + 1;
			if (int'(sram_addr) < int'(RGB_BASE)
				|| int'(sram_addr) >= int'(RGB_BASE) + 3 * PAIRS_PER_ROW * IMG_HEIGHT)
				stray_count <= stray_count + 1;
		end
	end

endmodule

/* test/tb_csc_top.sv */
/*
  Testbench for the CSC upsampler
  Loads YUV frames into the SRAM model, runs the DUT and checks every
  RGB word against a reference built from the filter and matrix rules
*/

`timescale 1ns/100ps

module tb_csc_top import csc_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int NUM_PAIRS = PAIRS_PER_ROW * IMG_HEIGHT;
	localparam int RGB_WORDS = 3 * NUM_PAIRS;
	localparam int SRC_WORDS = int'(V_BASE) + NUM_PAIRS / 2;    // Y, U and V planes
	localparam int RUN_CYCLES = 12 * NUM_PAIRS;
	localparam int NUM_RUNS = 5;
	localparam int WATCHDOG_CYCLES = 100 + NUM_RUNS * (SRC_WORDS + RUN_CYCLES + 40);

	logic CLOCK_50_I;
	logic resetn;
	logic start;
	logic busy, done;
	sram_addr_t sram_addr;
	sram_word_t sram_wdata, sram_rdata;
	logic sram_we_n;
	logic load_en, clear_counts;
	sram_addr_t load_addr;
	sram_word_t load_data;
	int write_count, stray_count;

	sram_word_t src_mem [SRC_WORDS];    // Frame as loaded
	logic [31:0] lfsr_state;
	int done_total = 0;
	int checks, errors;

	csc_top UUT (
		.CLOCK_50_I, .resetn, .start, .busy, .done,
		.sram_addr, .sram_wdata, .sram_we_n, .sram_rdata
	);

	sram_model mem_unit (
		.CLOCK_50_I, .sram_addr, .sram_wdata, .sram_we_n, .sram_rdata,
		.load_en, .load_addr, .load_data, .clear_counts, .write_count, .stray_count
	);

	initial begin
		CLOCK_50_I = 1'b0;
		forever #(CLK_PERIOD / 2) CLOCK_50_I = ~CLOCK_50_I;
	end

	always @(negedge CLOCK_50_I)
		if (done)
			done_total++;

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Something failed");
		$finish;
	end

	task automatic compare_word(input string name, input sram_word_t got, input sram_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_pixel(input string name, input pixel_t got, input pixel_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	task automatic compare_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = {1'b0, lfsr_state[31:1]} ^ (out ? 32'h80200003 : 32'h0);
		return out;
	endfunction

	function automatic pixel_t saturate(input int value);
		if (value < 0)
			return 8'h00;
		if (value > 255)
			return 8'hff;
		return value[7:0];
	endfunction

	function automatic int y_at(input int row, input int col);
		sram_word_t w;
		w = src_mem[int'(Y_BASE) + row * PAIRS_PER_ROW + col / 2];
		return (col % 2 == 0) ? int'(w[15:8]) : int'(w[7:0]);
	endfunction

	// Row edges repeat the first and last sample
	function automatic int chroma_at(input int base, input int row, input int col);
		sram_word_t w;
		int c;
		c = (col < 0) ? 0 : (col > CHROMA_PER_ROW - 1) ? CHROMA_PER_ROW - 1 : col;
		w = src_mem[base + row * (CHROMA_PER_ROW / 2) + c / 2];
		return (c % 2 == 0) ? int'(w[15:8]) : int'(w[7:0]);
	endfunction

	function automatic int odd_chroma(input int base, input int row, input int p);
		int acc;
		acc = 21 * (chroma_at(base, row, p - 2) + chroma_at(base, row, p + 3))
			- 52 * (chroma_at(base, row, p - 1) + chroma_at(base, row, p + 2))
			+ 159 * (chroma_at(base, row, p) + chroma_at(base, row, p + 1)) + 128;
		return int'(saturate(acc >>> 8));
	endfunction

	function automatic pixel_t red(input int y, input int u, input int v);
		return saturate((int'(COEF_Y) * (y - 16) + int'(COEF_RV) * (v - 128)) >>> 16);
	endfunction

	function automatic pixel_t green(input int y, input int u, input int v);
		return saturate((int'(COEF_Y) * (y - 16) - int'(COEF_GU) * (u - 128)
			- int'(COEF_GV) * (v - 128)) >>> 16);
	endfunction

	function automatic pixel_t blue(input int y, input int u, input int v);
		return saturate((int'(COEF_Y) * (y - 16) + int'(COEF_BU) * (u - 128)) >>> 16);
	endfunction

	task automatic fill_frame(input pixel_t level);
		for (int i = 0; i < SRC_WORDS; i++)
			src_mem[i] = {level, level};
	endtask

	task automatic random_frame();
		sram_word_t w;
		for (int i = 0; i < SRC_WORDS; i++) begin
			for (int b = 0; b < 16; b++)
				w = {w[14:0], lfsr_bit()};
			src_mem[i] = w;
		end
	endtask

	task automatic load_frame();
		for (int i = 0; i < SRC_WORDS; i++) begin
			@(negedge CLOCK_50_I);
			load_en = 1'b1;
			load_addr = sram_addr_t'(i);
			load_data = src_mem[i];
		end
		@(negedge CLOCK_50_I);
		load_en = 1'b0;
	endtask

	// One start pulse, then wait for done and look at the aftermath
	task automatic run_frame();
		int cycles;
		int done_before;
		@(negedge CLOCK_50_I);
		clear_counts = 1'b1;
		@(negedge CLOCK_50_I);
		clear_counts = 1'b0;
		done_before = done_total;
		start = 1'b1;
		@(negedge CLOCK_50_I);
		start = 1'b0;
		compare_bit("busy", busy, 1'b1);
		cycles = 0;
		while (!done && cycles < RUN_CYCLES) begin
			@(negedge CLOCK_50_I);
			cycles++;
		end
		if (!done) begin
			errors++;
			$display("No done pulse within %0d cycles of the start pulse", RUN_CYCLES);
		end
		repeat (20) @(negedge CLOCK_50_I);
		compare_count("done pulses", done_total - done_before, 1);
		compare_bit("busy", busy, 1'b0);
		compare_count("write count", write_count, RGB_WORDS);
		compare_count("stray writes", stray_count, 0);
	endtask

	task automatic check_frame();
		int row, p, y0, y1, ue, uo, ve, vo, addr;
		pixel_t r0, g0, b0, r1, g1, b1;
		sram_word_t exp_w [3];
		for (int pair = 0; pair < NUM_PAIRS; pair++) begin
			row = pair / PAIRS_PER_ROW;
			p = pair % PAIRS_PER_ROW;
			y0 = y_at(row, 2 * p);
			y1 = y_at(row, 2 * p + 1);
			ue = chroma_at(int'(U_BASE), row, p);
			ve = chroma_at(int'(V_BASE), row, p);
			uo = odd_chroma(int'(U_BASE), row, p);
			vo = odd_chroma(int'(V_BASE), row, p);
			r0 = red(y0, ue, ve);
			g0 = green(y0, ue, ve);
			b0 = blue(y0, ue, ve);
			r1 = red(y1, uo, vo);
			g1 = green(y1, uo, vo);
			b1 = blue(y1, uo, vo);
			exp_w[0] = {r0, g0};
			exp_w[1] = {b0, r1};
			exp_w[2] = {g1, b1};
			for (int k = 0; k < 3; k++) begin
				addr = int'(RGB_BASE) + 3 * pair + k;
				compare_word($sformatf("mem[%0d]", addr), mem_unit.mem[addr], exp_w[k]);
			end
		end
	endtask

	// Source planes must come out untouched
	task automatic check_source();
		for (int i = 0; i < SRC_WORDS; i++)
			compare_word($sformatf("mem[%0d]", i), mem_unit.mem[i], src_mem[i]);
	endtask

	task automatic report(input string name, input int chk_before, input int err_before);
		$display("%s: %0d checks, %0d errors", name, checks - chk_before, errors - err_before);
	endtask

	task automatic test_reset();
		int chk_before, err_before;
		chk_before = checks;
		err_before = errors;
		repeat (5) @(negedge CLOCK_50_I);
		compare_bit("sram_we_n", sram_we_n, 1'b1);
		compare_bit("busy", busy, 1'b0);
		compare_bit("done", done, 1'b0);
		compare_count("write count", write_count, 0);
		compare_count("done pulses", done_total, 0);
		report("reset", chk_before, err_before);
	endtask

	task automatic test_flat();
		int chk_before, err_before;
		chk_before = checks;
		err_before = errors;
		fill_frame(8'd128);
		load_frame();
		run_frame();
		check_frame();
		report("flat frame", chk_before, err_before);
	endtask

	task automatic test_random();
		int chk_before, err_before;
		chk_before = checks;
		err_before = errors;
		random_frame();
		load_frame();
		run_frame();
		check_frame();
		check_source();
		report("lfsr frame", chk_before, err_before);
	endtask

	task automatic test_saturation();
		int chk_before, err_before;
		sram_word_t w0, w1;
		chk_before = checks;
		err_before = errors;
		fill_frame(8'd255);
		load_frame();
		run_frame();
		check_frame();
		w0 = mem_unit.mem[int'(RGB_BASE)];
		w1 = mem_unit.mem[int'(RGB_BASE) + 1];
		compare_pixel("r_even", w0[15:8], 8'hff);    // Top of range
		compare_pixel("b_even", w1[15:8], 8'hff);
		fill_frame(8'd0);
		load_frame();
		run_frame();
		check_frame();
		w0 = mem_unit.mem[int'(RGB_BASE)];
		w1 = mem_unit.mem[int'(RGB_BASE) + 1];
		compare_pixel("r_even", w0[15:8], 8'h00);
		compare_pixel("b_even", w1[15:8], 8'h00);
		report("saturation", chk_before, err_before);
	endtask

	task automatic test_restart();
		int chk_before, err_before;
		chk_before = checks;
		err_before = errors;
		random_frame();    // LFSR carries on into a new image
		load_frame();
		run_frame();
		check_frame();
		report("restart", chk_before, err_before);
	endtask

	initial begin
		resetn = 1'b0;
		start = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		clear_counts = 1'b1;
		checks = 0;
		errors = 0;
		lfsr_state = 32'hfc1f;
		repeat (10) @(negedge CLOCK_50_I);
		resetn = 1'b1;
		clear_counts = 1'b0;

		test_reset();
		test_flat();
		test_random();
		test_saturation();
		test_restart();

		$display("Total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* csc_upsampler.f */
common/csc_pkg.sv
hdl/sram_arbiter.sv
upsample/yuv_fetch.sv
upsample/chroma_interpolator.sv
hdl/csc_matrix.sv
hdl/rgb_store.sv
hdl/csc_top.sv
test/sram_model.sv
test/tb_csc_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

verilator --binary -Wno-fatal --top-module tb_csc_top -f csc_upsampler.f -o tb_csc_top \
	&& ./obj_dir/tb_csc_top > "$log" 2>&1 \
	|| { cat "$log" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$log"
grep -qx "Everything OK" "$log" \
	&& echo "Result: pass" \
	|| { echo "Result: fail"; exit 1; }
